//--- all.f
+incdir+dv
hdl/flit_pkg.sv
hdl/route_pkg.sv
hdl/input_fifo.sv
hdl/output_arbiter.sv
hdl/router.sv
hdl/noc_top.sv
dv/noc_tb.sv

//--- dv/noc_model.svh
`ifndef NOC_MODEL_SVH
`define NOC_MODEL_SVH

flit_t exp_q [NUM_NODES * NUM_NODES][$];                // Index is dest * NUM_NODES + src.
int    errors;
int    in_flight;                                       // Admitted and not yet delivered.
int    inj_credits [NUM_NODES];                         // Free slots in each injection FIFO.
int    sink_credits [NUM_NODES];                        // Slots the ejection port may still fill.
int    credit_pulses [NUM_NODES];
int    injected [NUM_NODES];
int    open_src [NUM_NODES];                            // Source of the packet in progress, or -1.

task automatic compare_values(input string name, input logic [31:0] got,
                              input logic [31:0] want);
    if (got !== want) begin
        $display("MISMATCH %s: got 0x%0h, expected 0x%0h", name, got, want);
        errors++;
    end
endtask

function automatic int flits_outstanding();
    int n;
    n = 0;
    for (int i = 0; i < NUM_NODES * NUM_NODES; i++) begin
        n += exp_q[i].size();
    end
    return n;
endfunction

task automatic record_sent(input flit_t f);
    exp_q[int'(f.dest) * NUM_NODES + int'(f.src)].push_back(f);
    injected[f.src]++;
endtask

// Oldest flit of the pair, and no packet may split another one.
task automatic check_delivery(input int node, input flit_t f);
    int    idx;
    bit    starts;
    flit_t want;
    idx    = node * NUM_NODES + int'(f.src);
    starts = (f.flit_type == FLIT_HEAD) || (f.flit_type == FLIT_SINGLE);
    if (exp_q[idx].size() == 0) begin
        $display("ERROR: node %0d got a flit from node %0d that was never sent", node, f.src);
        errors++;
    end else begin
        want = exp_q[idx].pop_front();
        compare_values($sformatf("out_flit[%0d]", node), 32'(f), 32'(want));
    end
    if (starts ? (open_src[node] != -1) : (open_src[node] != int'(f.src))) begin
        $display("ERROR: packet from node %0d interleaved with another at node %0d",
                 f.src, node);
        errors++;
    end
    open_src[node] = (f.flit_type == FLIT_HEAD || f.flit_type == FLIT_BODY) ? int'(f.src) : -1;
endtask

`endif

//--- dv/noc_tb.sv
`timescale 1ns/1ps

module noc_tb;

    import flit_pkg::*;
    import route_pkg::*;

    localparam int BUFFER_SIZE = 8;

    logic  clk;
    logic  rst_n;
    flit_t in_flit [NUM_NODES];
    logic  in_valid [NUM_NODES];
    logic  in_credit [NUM_NODES];
    flit_t out_flit [NUM_NODES];
    logic  out_valid [NUM_NODES];
    logic  out_credit [NUM_NODES];

    `include "noc_model.svh"

    int    seed = 32'h76e9c5ce;
    int    cycles = 0;
    int    planned = 0;                                 // Flits queued so far.
    int    fails = 0;
    int    mark = 0;
    int    seen;
    bit    running = 1'b0;
    flit_t tx_q [NUM_NODES][$];
    int    tx_len [NUM_NODES][$];
    int    remaining [NUM_NODES];                       // Flits left of the admitted packet.
    int    pkt_no [NUM_NODES];
    int    ret_wait [NUM_NODES];                        // Consumed flits not yet credited.
    int    ret_delay [NUM_NODES];
    int    delivered [NUM_NODES];
    bit    hold [NUM_NODES];

    noc_top #(.BUFFER_SIZE(BUFFER_SIZE)) i_dut (
        .clk(clk), .rst_n(rst_n),
        .in_flit(in_flit), .in_valid(in_valid), .in_credit(in_credit),
        .out_flit(out_flit), .out_valid(out_valid), .out_credit(out_credit)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic int rand_below(input int n);
        return ($random(seed) & 32'h7fff_ffff) % n;
    endfunction

    task automatic queue_packet(input int src, input int dest, input int len);
        flit_t f;
        for (int i = 0; i < len; i++) begin
            f.flit_type = (len == 1) ? FLIT_SINGLE : (i == 0) ? FLIT_HEAD :
                          (i == len - 1) ? FLIT_TAIL : FLIT_BODY;
            f.src       = NODE_W'(src);
            f.dest      = NODE_W'(dest);
            f.payload   = PAYLOAD_W'(pkt_no[src] * 4 + i);  // Packet number and flit index.
            tx_q[src].push_back(f);
        end
        tx_len[src].push_back(len);
        pkt_no[src]++;
        planned += len;
    endtask

    task automatic wait_idle();
        bit busy;
        do begin
            @(negedge clk);
            busy = (in_flight != 0);
            for (int n = 0; n < NUM_NODES; n++) begin
                busy |= (tx_q[n].size() != 0) || (ret_wait[n] != 0);
            end
        end while (busy);
        repeat (10) @(negedge clk);                     // Let the last credits land.
    endtask

    task automatic end_test(input string name);
        $display("test %s: %s, %0d errors", name, (errors == mark) ? "ok" : "failed",
                 errors - mark);
        fails += (errors != mark);
        mark   = errors;
    endtask

    always @(posedge clk) begin
        cycles++;
        if (cycles > 200 * planned + 1000) begin
            $display("ERROR: timeout at cycle %0d, traffic did not drain", cycles);
            $display("FAIL: see errors above");
            $finish;
        end
    end

    // Endpoint sources and sinks, sampled and driven mid-cycle.
    always @(negedge clk) begin
        int s;
        if (running) begin
            for (int n = 0; n < NUM_NODES; n++) begin
                if (in_credit[n]) begin
                    inj_credits[n]++;
                    credit_pulses[n]++;
                end
                if (out_valid[n]) begin
                    if (sink_credits[n] == 0) begin
                        $display("ERROR: node %0d got a flit with no credit outstanding", n);
                        errors++;
                    end
                    sink_credits[n]--;
                    in_flight--;
                    delivered[n]++;
                    ret_wait[n]++;
                    check_delivery(n, out_flit[n]);
                end
                out_credit[n] = 1'b0;
                if (!hold[n] && ret_wait[n] > 0) begin
                    if (ret_delay[n] == 0) begin
                        out_credit[n] = 1'b1;
                        ret_wait[n]--;
                        sink_credits[n]++;
                        ret_delay[n] = rand_below(4);   // Idle cycles before the next one.
                    end else begin
                        ret_delay[n]--;
                    end
                end
            end
            for (int k = 0; k < NUM_NODES; k++) begin
                s = (k + cycles) % NUM_NODES;           // Rotate who is admitted first.
                in_valid[s] = 1'b0;
                if (remaining[s] == 0 && tx_len[s].size() != 0 &&
                        in_flight + tx_len[s][0] <= BUFFER_SIZE) begin
                    remaining[s] = tx_len[s].pop_front();
                    in_flight   += remaining[s];        // Whole packet admitted at once.
                end
                if (remaining[s] != 0 && inj_credits[s] != 0 && rand_below(4) != 0) begin
                    in_flit[s]  = tx_q[s].pop_front();
                    in_valid[s] = 1'b1;
                    inj_credits[s]--;
                    remaining[s]--;
                    record_sent(in_flit[s]);
                end
            end
        end
    end

    initial begin
        rst_n = 1'b0;
        for (int n = 0; n < NUM_NODES; n++) begin
            in_flit[n]      = '0;
            in_valid[n]     = 1'b0;
            out_credit[n]   = 1'b0;
            inj_credits[n]  = BUFFER_SIZE;
            sink_credits[n] = BUFFER_SIZE;
            open_src[n]     = -1;
        end
        for (int c = 0; c < 6; c++) begin
            @(negedge clk);
            for (int n = 0; n < NUM_NODES; n++) begin
                compare_values($sformatf("out_valid[%0d]", n), 32'(out_valid[n]), '0);
                compare_values($sformatf("in_credit[%0d]", n), 32'(in_credit[n]), '0);
            end
            rst_n = (c >= 4);                           // Five cycles in reset.
        end
        end_test("reset");
        running = 1'b1;
        for (int s = 0; s < NUM_NODES; s++) begin
            for (int d = 0; d < 2 * NUM_NODES; d++) begin
                queue_packet(s, d % NUM_NODES, 1);
            end
        end
        wait_idle();
        end_test("single_flit");
        for (int k = 0; k < 20; k++) begin
            for (int s = 0; s < NUM_NODES; s++) begin
                queue_packet(s, rand_below(NUM_NODES), 1 + rand_below(4));
            end
        end
        wait_idle();
        compare_values("expected flits left", flits_outstanding(), 0);
        end_test("contention");
        hold[2] = 1'b1;
        seen    = delivered[2];
        for (int k = 0; k < 6; k++) begin
            for (int s = 0; s < NUM_NODES; s++) begin
                queue_packet(s, 2, 1 + rand_below(4));
            end
        end
        repeat (100) @(negedge clk);
        compare_values("flits into node 2 while held", delivered[2] - seen, BUFFER_SIZE);
        hold[2] = 1'b0;
        wait_idle();
        end_test("back_pressure");
        for (int n = 0; n < NUM_NODES; n++) begin
            compare_values($sformatf("in_credit[%0d] pulses", n), credit_pulses[n],
                           injected[n]);
        end
        end_test("credit_return");
        $display("Summary: 5 tests, %0d failed, %0d errors", fails, errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

//--- hdl/flit_pkg.sv
package flit_pkg;

    localparam int NODE_W    = 2;                       // Node id width.
    localparam int PAYLOAD_W = 16;                      // Payload field width.

    // Flit type doubles as the packet opcode.
    typedef enum logic [1:0] {
        FLIT_HEAD   = 2'b00,                            // First flit of a multi-flit packet.
        FLIT_BODY   = 2'b01,                            // Middle flit.
        FLIT_TAIL   = 2'b10,                            // Last flit, releases the path.
        FLIT_SINGLE = 2'b11                             // Head and tail in one flit.
    } flit_type_e;

    // 22 bits in total, type in the top bits.
    typedef struct packed {
        flit_type_e             flit_type;
        logic [NODE_W-1:0]      src;                    // Injecting node.
        logic [NODE_W-1:0]      dest;                   // Target node, repeated in every flit.
        logic [PAYLOAD_W-1:0]   payload;
    } flit_t;

endpackage

//--- hdl/input_fifo.sv
`timescale 1ns/1ps

module input_fifo #(
    parameter int BUFFER_SIZE = 8
) (
    input  logic            clk,
    input  logic            rst_n,
    input  flit_pkg::flit_t wr_flit,
    input  logic            wr_valid,
    output flit_pkg::flit_t head_flit,
    output logic            head_valid,
    input  logic            pop,
    output logic            credit
);

    import flit_pkg::*;

    localparam int PTR_W = (BUFFER_SIZE > 1) ? $clog2(BUFFER_SIZE) : 1;
    localparam int CNT_W = $clog2(BUFFER_SIZE + 1);

    flit_t            mem [BUFFER_SIZE];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;

    assign head_flit  = mem[rd_ptr];                    // Oldest flit.
    assign head_valid = (count != '0);

    // Upstream only sends with credit, so a write never finds the buffer full.
    always_ff @(posedge clk) begin
        if (wr_valid) begin
            mem[wr_ptr] <= wr_flit;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
            credit <= 1'b0;
        end else begin
            credit <= pop;                              // One credit per freed slot.
            if (wr_valid) begin
                wr_ptr <= (wr_ptr == PTR_W'(BUFFER_SIZE - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(BUFFER_SIZE - 1)) ? '0 : rd_ptr + 1'b1;
            end
            count <= count + CNT_W'(wr_valid) - CNT_W'(pop);
        end
    end

endmodule

//--- hdl/noc_top.sv
`timescale 1ns/1ps

module noc_top #(
    parameter int BUFFER_SIZE = 8
) (
    input  logic            clk,
    input  logic            rst_n,
    input  flit_pkg::flit_t in_flit [route_pkg::NUM_NODES],
    input  logic            in_valid [route_pkg::NUM_NODES],
    output logic            in_credit [route_pkg::NUM_NODES],
    output flit_pkg::flit_t out_flit [route_pkg::NUM_NODES],
    output logic            out_valid [route_pkg::NUM_NODES],
    input  logic            out_credit [route_pkg::NUM_NODES]
);

    import flit_pkg::*;
    import route_pkg::*;

    localparam int R0_IN  = num_in_ports(0);
    localparam int R0_OUT = num_out_ports(0);
    localparam int R1_IN  = num_in_ports(1);
    localparam int R1_OUT = num_out_ports(1);
    localparam int R2_IN  = num_in_ports(2);
    localparam int R2_OUT = num_out_ports(2);
    localparam int R3_IN  = num_in_ports(3);
    localparam int R3_OUT = num_out_ports(3);

    flit_t r0_in_flit [R0_IN];
    logic  r0_in_valid [R0_IN];
    logic  r0_in_credit [R0_IN];
    flit_t r0_out_flit [R0_OUT];
    logic  r0_out_valid [R0_OUT];
    logic  r0_out_credit [R0_OUT];

    flit_t r1_in_flit [R1_IN];
    logic  r1_in_valid [R1_IN];
    logic  r1_in_credit [R1_IN];
    flit_t r1_out_flit [R1_OUT];
    logic  r1_out_valid [R1_OUT];
    logic  r1_out_credit [R1_OUT];

    flit_t r2_in_flit [R2_IN];
    logic  r2_in_valid [R2_IN];
    logic  r2_in_credit [R2_IN];
    flit_t r2_out_flit [R2_OUT];
    logic  r2_out_valid [R2_OUT];
    logic  r2_out_credit [R2_OUT];

    flit_t r3_in_flit [R3_IN];
    logic  r3_in_valid [R3_IN];
    logic  r3_in_credit [R3_IN];
    flit_t r3_out_flit [R3_OUT];
    logic  r3_out_valid [R3_OUT];
    logic  r3_out_credit [R3_OUT];

    router #(.NODE(0), .NUM_IN(R0_IN), .NUM_OUT(R0_OUT), .BUFFER_SIZE(BUFFER_SIZE)) i_router0 (
        .clk(clk), .rst_n(rst_n),
        .in_flit(r0_in_flit), .in_valid(r0_in_valid), .in_credit(r0_in_credit),
        .out_flit(r0_out_flit), .out_valid(r0_out_valid), .out_credit(r0_out_credit)
    );

    router #(.NODE(1), .NUM_IN(R1_IN), .NUM_OUT(R1_OUT), .BUFFER_SIZE(BUFFER_SIZE)) i_router1 (
        .clk(clk), .rst_n(rst_n),
        .in_flit(r1_in_flit), .in_valid(r1_in_valid), .in_credit(r1_in_credit),
        .out_flit(r1_out_flit), .out_valid(r1_out_valid), .out_credit(r1_out_credit)
    );

    router #(.NODE(2), .NUM_IN(R2_IN), .NUM_OUT(R2_OUT), .BUFFER_SIZE(BUFFER_SIZE)) i_router2 (
        .clk(clk), .rst_n(rst_n),
        .in_flit(r2_in_flit), .in_valid(r2_in_valid), .in_credit(r2_in_credit),
        .out_flit(r2_out_flit), .out_valid(r2_out_valid), .out_credit(r2_out_credit)
    );

    router #(.NODE(3), .NUM_IN(R3_IN), .NUM_OUT(R3_OUT), .BUFFER_SIZE(BUFFER_SIZE)) i_router3 (
        .clk(clk), .rst_n(rst_n),
        .in_flit(r3_in_flit), .in_valid(r3_in_valid), .in_credit(r3_in_credit),
        .out_flit(r3_out_flit), .out_valid(r3_out_valid), .out_credit(r3_out_credit)
    );

    // Router 0: local, and the link from node 3.
    assign r0_in_flit[0]    = in_flit[0];
    assign r0_in_valid[0]   = in_valid[0];
    assign r0_in_flit[1]    = r3_out_flit[1];           // Link 3.out1 -> 0.in1.
    assign r0_in_valid[1]   = r3_out_valid[1];
    assign r0_out_credit[0] = out_credit[0];
    assign r0_out_credit[1] = r2_in_credit[1];

    // Router 1.
    assign r1_in_flit[0]    = in_flit[1];
    assign r1_in_valid[0]   = in_valid[1];
    assign r1_in_flit[1]    = r3_out_flit[2];           // Link 3.out2 -> 1.in1.
    assign r1_in_valid[1]   = r3_out_valid[2];
    assign r1_out_credit[0] = out_credit[1];
    assign r1_out_credit[1] = r2_in_credit[2];

    // Router 2 merges traffic from nodes 0 and 1
    assign r2_in_flit[0]    = in_flit[2];
    assign r2_in_valid[0]   = in_valid[2];
    assign r2_in_flit[1]    = r0_out_flit[1];           // Link 0.out1 -> 2.in1.
    assign r2_in_valid[1]   = r0_out_valid[1];
    assign r2_in_flit[2]    = r1_out_flit[1];           // Link 1.out1 -> 2.in2.
    assign r2_in_valid[2]   = r1_out_valid[1];
    assign r2_out_credit[0] = out_credit[2];
    assign r2_out_credit[1] = r3_in_credit[1];

    // Router 3.
    assign r3_in_flit[0]    = in_flit[3];
    assign r3_in_valid[0]   = in_valid[3];
    assign r3_in_flit[1]    = r2_out_flit[1];           // Link 2.out1 -> 3.in1.
    assign r3_in_valid[1]   = r2_out_valid[1];
    assign r3_out_credit[0] = out_credit[3];
    assign r3_out_credit[1] = r0_in_credit[1];
    assign r3_out_credit[2] = r1_in_credit[1];

    // Endpoint side.
    assign in_credit[0] = r0_in_credit[0];
    assign in_credit[1] = r1_in_credit[0];
    assign in_credit[2] = r2_in_credit[0];
    assign in_credit[3] = r3_in_credit[0];
    assign out_flit[0]  = r0_out_flit[0];
    assign out_flit[1]  = r1_out_flit[0];
    assign out_flit[2]  = r2_out_flit[0];
    assign out_flit[3]  = r3_out_flit[0];
    assign out_valid[0] = r0_out_valid[0];
    assign out_valid[1] = r1_out_valid[0];
    assign out_valid[2] = r2_out_valid[0];
    assign out_valid[3] = r3_out_valid[0];

endmodule

//--- hdl/output_arbiter.sv
`timescale 1ns/1ps

module output_arbiter #(
    parameter int NUM_IN      = 2,
    parameter int BUFFER_SIZE = 8
) (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            req [NUM_IN],
    input  flit_pkg::flit_t head_flit [NUM_IN],
    output logic            grant [NUM_IN],
    output flit_pkg::flit_t link_flit,
    output logic            link_valid,
    input  logic            link_credit
);

    import flit_pkg::*;

    localparam int IDX_W = (NUM_IN > 1) ? $clog2(NUM_IN) : 1;
    localparam int CNT_W = $clog2(BUFFER_SIZE + 1);

    logic [IDX_W-1:0] last_idx;                         // Most recent winner.
    logic [IDX_W-1:0] lock_idx;                         // Input owning the link mid-packet.
    logic [IDX_W-1:0] sel_idx;
    logic             locked;
    logic             any_grant;
    logic [CNT_W-1:0] credits;                          // Free slots downstream.
    flit_t            sel_flit;

    // Pick a winner, starting one past the last one.
    always_comb begin
        sel_idx   = last_idx;
        any_grant = 1'b0;
        if (credits != '0) begin
            if (locked) begin
                sel_idx   = lock_idx;                   // Wormhole, stay on the packet.
                any_grant = req[lock_idx];
            end else begin
                for (int k = 1; k <= NUM_IN; k++) begin
                    if (!any_grant && req[(int'(last_idx) + k) % NUM_IN]) begin
                        sel_idx   = IDX_W'((int'(last_idx) + k) % NUM_IN);
                        any_grant = 1'b1;
                    end
                end
            end
        end
    end

    always_comb begin
        for (int i = 0; i < NUM_IN; i++) begin
            grant[i] = any_grant && (sel_idx == IDX_W'(i));
        end
    end

    assign sel_flit = head_flit[sel_idx];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            last_idx   <= '0;
            lock_idx   <= '0;
            locked     <= 1'b0;
            credits    <= CNT_W'(BUFFER_SIZE);          // Downstream buffer starts empty.
            link_valid <= 1'b0;
        end else begin
            link_valid <= any_grant;
            credits    <= credits - CNT_W'(any_grant) + CNT_W'(link_credit);
            if (any_grant) begin
                last_idx <= sel_idx;
                if (sel_flit.flit_type == FLIT_HEAD) begin
                    locked   <= 1'b1;
                    lock_idx <= sel_idx;
                end else if (sel_flit.flit_type == FLIT_TAIL) begin
                    locked <= 1'b0;                     // Packet done, reopen arbitration.
                end
            end
        end
    end

    // Output flit register, qualified by link_valid.
    always_ff @(posedge clk) begin
        if (any_grant) begin
            link_flit <= sel_flit;
        end
    end

endmodule

//--- hdl/route_pkg.sv
package route_pkg;

    import flit_pkg::*;

    localparam int NUM_NODES = 4;                       // Routers in the network.
    localparam int PORT_W    = 2;                       // Wide enough for three outputs.

    // Input ports per node: local plus incoming links.
    function automatic int num_in_ports(input int node);
        case (node)
            2:       return 3;                          // Fed by nodes 0 and 1.
            default: return 2;
        endcase
    endfunction

    // Output ports per node: local plus outgoing links.
    function automatic int num_out_ports(input int node);
        case (node)
            3:       return 3;                          // Feeds nodes 0 and 1.
            default: return 2;
        endcase
    endfunction

    // Fixed routing table for the ring-like topology.
    //   0 -> 2, 1 -> 2, 2 -> 3, 3 -> 0 and 1
    function automatic logic [PORT_W-1:0] out_port(input int node,
                                                   input logic [NODE_W-1:0] dest);
        if (int'(dest) == node) begin
            return PORT_W'(0);                          // Eject to the local endpoint.
        end
        if (node == 3) begin
            if (dest == NODE_W'(0)) begin
                return PORT_W'(1);                      // Direct link to node 0.
            end
            return PORT_W'(2);                          // Everything else goes via node 1.
        end
        return PORT_W'(1);                              // Single outgoing link.
    endfunction

endpackage

//--- hdl/router.sv
`timescale 1ns/1ps

module router #(
    parameter int NODE        = 0,
    parameter int NUM_IN      = 2,
    parameter int NUM_OUT     = 2,
    parameter int BUFFER_SIZE = 8
) (
    input  logic            clk,
    input  logic            rst_n,
    input  flit_pkg::flit_t in_flit [NUM_IN],
    input  logic            in_valid [NUM_IN],
    output logic            in_credit [NUM_IN],
    output flit_pkg::flit_t out_flit [NUM_OUT],
    output logic            out_valid [NUM_OUT],
    input  logic            out_credit [NUM_OUT]
);

    import flit_pkg::*;
    import route_pkg::*;

    flit_t             head_flit [NUM_IN];
    logic              head_valid [NUM_IN];
    logic              pop [NUM_IN];
    logic [PORT_W-1:0] dest_port [NUM_IN];              // Routed output per FIFO head.
    logic              req [NUM_OUT][NUM_IN];
    logic              grant [NUM_OUT][NUM_IN];

    // Input buffers.
    for (genvar i = 0; i < NUM_IN; i++) begin : g_in
        input_fifo #(
            .BUFFER_SIZE(BUFFER_SIZE)
        ) i_fifo (
            .clk(clk),
            .rst_n(rst_n),
            .wr_flit(in_flit[i]),
            .wr_valid(in_valid[i]),
            .head_flit(head_flit[i]),
            .head_valid(head_valid[i]),
            .pop(pop[i]),
            .credit(in_credit[i])
        );
    end

    // Route lookup on every head.
    always_comb begin
        for (int i = 0; i < NUM_IN; i++) begin
            dest_port[i] = out_port(NODE, head_flit[i].dest);
        end
    end

    always_comb begin
        for (int o = 0; o < NUM_OUT; o++) begin
            for (int i = 0; i < NUM_IN; i++) begin
                req[o][i] = head_valid[i] && (dest_port[i] == PORT_W'(o));
            end
        end
    end

    // A head requests one output only, so OR of grants is safe.
    always_comb begin
        for (int i = 0; i < NUM_IN; i++) begin
            pop[i] = 1'b0;
            for (int o = 0; o < NUM_OUT; o++) begin
                pop[i] = pop[i] | grant[o][i];
            end
        end
    end

    // Output arbiters, which also form the crossbar mux.
    for (genvar o = 0; o < NUM_OUT; o++) begin : g_out
        output_arbiter #(
            .NUM_IN(NUM_IN),
            .BUFFER_SIZE(BUFFER_SIZE)
        ) i_arb (
            .clk(clk),
            .rst_n(rst_n),
            .req(req[o]),
            .head_flit(head_flit),
            .grant(grant[o]),
            .link_flit(out_flit[o]),
            .link_valid(out_valid[o]),
            .link_credit(out_credit[o])
        );
    end

endmodule

//--- run.sh
#!/bin/sh
# Build with Verilator, run, and judge the result from the log.
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing -Wno-fatal --top-module noc_tb -f all.f -o noc_sim \
    && ./obj_dir/noc_sim > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "Build or simulation error"; exit 1; }
cat sim.log
grep -qx "PASS: all tests" sim.log \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }
